// File: rtl/vga_timing_pkg.sv
package vga_timing_pkg;

	// ==========================================================
	// 640x480 raster, 60 Hz frame on a 25 MHz pixel clock
	// ==========================================================

	// Horizontal timing in pixel clocks, 800 per line
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;

	// Vertical timing in lines, 525 per frame
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;

	// Screen coordinate, also wide enough for the blanking region
	typedef logic [9:0] coord_t;

	// ==========================================================
	// Raster position as seen by the pixel pipeline
	// ==========================================================

	// Sync flags are active low
	// frame_start is a single pulse at position (0,0)
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
		logic   hsync;
		logic   vsync;
		logic   frame_start;
	} raster_t;

endpackage

// File: rtl/game_pkg.sv
package game_pkg;

	// ==========================================================
	// APB register map, byte addresses
	// ==========================================================

	localparam logic [7:0] REG_BALL     = 8'h00;
	localparam logic [7:0] REG_PADDLE_L = 8'h04;
	localparam logic [7:0] REG_PADDLE_R = 8'h08;
	localparam logic [7:0] REG_MODE     = 8'h0C;
	localparam logic [7:0] REG_LIVES    = 8'h10;

	// ==========================================================
	// Object geometry in pixels
	// ==========================================================

	localparam int BALL_W   = 20;
	localparam int BALL_H   = 20;
	localparam int PADDLE_W = 20;
	localparam int PADDLE_H = 100;

	// Three strings spanning the full width
	localparam int STRING_X = 0;
	localparam int STRING_W = 640;
	localparam int STRING_H = 3;
	localparam int STRING_Y [3] = '{37, 62, 87};

	// Mode box and game-over box share one size
	localparam int BOX_W      = 100;
	localparam int BOX_H      = 100;
	localparam int MODE_BOX_X = 120;
	localparam int MODE_BOX_Y = 120;
	localparam int OVER_BOX_X = 220;
	localparam int OVER_BOX_Y = 120;

	// Lives squares along the bottom edge
	localparam int LIFE_SIZE = 10;
	localparam int LIFE_Y    = 460;
	localparam int LIFE_P1_X [3] = '{20, 40, 60};
	localparam int LIFE_P2_X [3] = '{600, 580, 560};

	// ==========================================================
	// Colors
	// ==========================================================

	typedef logic [2:0]  color_idx_t;
	typedef logic [23:0] rgb_t;

	localparam color_idx_t IDX_BG     = 3'd0;
	localparam color_idx_t IDX_WHITE  = 3'd2;
	localparam color_idx_t IDX_RED    = 3'd3;
	localparam color_idx_t IDX_GREEN  = 3'd4;
	localparam color_idx_t IDX_YELLOW = 3'd5;
	localparam color_idx_t IDX_BLACK  = 3'd6;

	// Entries 1 and 7 are spare, shown grey
	localparam rgb_t PALETTE [8] = '{
		24'h102040, 24'h808080, 24'hFFFFFF, 24'hFF0000,
		24'h00FF00, 24'hFFFF00, 24'h000000, 24'h808080
	};

	// ==========================================================
	// Game state
	// ==========================================================

	typedef logic [2:0] lives_t;

	typedef enum logic [1:0] {
		MODE_MENU,
		MODE_SINGLE,
		MODE_MULTI,
		MODE_OVER
	} game_mode_e;

	typedef struct packed {
		vga_timing_pkg::coord_t ball_x;
		vga_timing_pkg::coord_t ball_y;
		vga_timing_pkg::coord_t pl_x;
		vga_timing_pkg::coord_t pl_y;
		vga_timing_pkg::coord_t pr_x;
		vga_timing_pkg::coord_t pr_y;
		game_mode_e             mode;
		lives_t                 p1_lives;
		lives_t                 p2_lives;
	} game_state_t;

endpackage

// File: rtl/raster_timing.sv
`timescale 1ns/1ps

module raster_timing #(
	parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
	parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
	parameter int H_BACK   = vga_timing_pkg::H_BACK,
	parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
	parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
	parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	output vga_timing_pkg::raster_t raster
);

	// Line and frame totals, sync windows follow the front porch
	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	vga_timing_pkg::coord_t  h_cnt;
	vga_timing_pkg::coord_t  v_cnt;
	logic                    h_last;
	logic                    v_last;
	vga_timing_pkg::raster_t raster_next;

	assign h_last = (int'(h_cnt) == H_TOTAL - 1);
	assign v_last = (int'(v_cnt) == V_TOTAL - 1);

	// ==========================================================
	// Position counters
	// ==========================================================

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			v_cnt <= v_last ? '0 : v_cnt + 1'b1;
		end
		else
		begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Decode of the current counter position
	always_comb
	begin
		raster_next.x           = h_cnt;
		raster_next.y           = v_cnt;
		raster_next.active      = (int'(h_cnt) < H_ACTIVE) && (int'(v_cnt) < V_ACTIVE);
		raster_next.hsync       = !((int'(h_cnt) >= H_SYNC_START) && (int'(h_cnt) < H_SYNC_END));
		raster_next.vsync       = !((int'(v_cnt) >= V_SYNC_START) && (int'(v_cnt) < V_SYNC_END));
		raster_next.frame_start = (h_cnt == '0) && (v_cnt == '0);
	end

	// Registered so every field changes on the same edge
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			raster.x           <= '0;
			raster.y           <= '0;
			raster.active      <= 1'b0;
			raster.hsync       <= 1'b1;
			raster.vsync       <= 1'b1;
			raster.frame_start <= 1'b0;
		end
		else
		begin
			raster <= raster_next;
		end
	end

endmodule

// File: rtl/apb_game_regs.sv
`timescale 1ns/1ps

module apb_game_regs (
	input  logic                  iVGA_CLK,
	input  logic                  iRST_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [7:0]            paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output game_pkg::game_state_t live_state
);

	logic access;
	logic addr_hit;

	// Access phase of a transfer
	assign access = psel && penable;

	// No wait states
	assign pready = 1'b1;

	// ==========================================================
	// Address decode and read mux
	// ==========================================================

	always_comb
	begin
		addr_hit = 1'b1;
		prdata   = '0;
		case (paddr)
			game_pkg::REG_BALL:
				prdata = {6'b0, live_state.ball_x, 6'b0, live_state.ball_y};
			game_pkg::REG_PADDLE_L:
				prdata = {6'b0, live_state.pl_x, 6'b0, live_state.pl_y};
			game_pkg::REG_PADDLE_R:
				prdata = {6'b0, live_state.pr_x, 6'b0, live_state.pr_y};
			game_pkg::REG_MODE:
				prdata = {30'b0, live_state.mode};
			game_pkg::REG_LIVES:
				prdata = {25'b0, live_state.p1_lives, 1'b0, live_state.p2_lives};
			default:
				addr_hit = 1'b0;
		endcase
	end

	// Error only in the access cycle of an unmapped address
	assign pslverr = access && !addr_hit;

	// ==========================================================
	// Register writes
	// ==========================================================

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			live_state <= '0;
		end
		else if (access && pwrite && addr_hit)
		begin
			case (paddr)
				game_pkg::REG_BALL:
				begin
					live_state.ball_x <= pwdata[25:16];
					live_state.ball_y <= pwdata[9:0];
				end
				game_pkg::REG_PADDLE_L:
				begin
					live_state.pl_x <= pwdata[25:16];
					live_state.pl_y <= pwdata[9:0];
				end
				game_pkg::REG_PADDLE_R:
				begin
					live_state.pr_x <= pwdata[25:16];
					live_state.pr_y <= pwdata[9:0];
				end
				game_pkg::REG_MODE:
					live_state.mode <= game_pkg::game_mode_e'(pwdata[1:0]);
				game_pkg::REG_LIVES:
				begin
					live_state.p1_lives <= pwdata[6:4];
					live_state.p2_lives <= pwdata[2:0];
				end
			endcase
		end
	end

endmodule

// File: rtl/frame_shadow.sv
`timescale 1ns/1ps

module frame_shadow (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  vga_timing_pkg::raster_t raster,
	input  game_pkg::game_state_t   live_state,
	output game_pkg::game_state_t   frame_state
);

	// ==========================================================
	// Snapshot of the game state, one per frame
	// ==========================================================

	// Host writes can land at any time during scan-out.
	// Holding a copy from frame start keeps every pixel of a
	// frame on the same object positions, so a moving ball
	// or paddle is never drawn half at its old place.

	logic load;

	// Only the frame start pulse matters here
	assign load = raster.frame_start;

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			frame_state <= '0;
		end
		else if (load)
		begin
			// Visible to the compositor from the next cycle
			frame_state <= live_state;
		end
	end

endmodule

// File: rtl/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  vga_timing_pkg::raster_t raster,
	input  game_pkg::game_state_t   frame_state,
	output logic [7:0]              r_data,
	output logic [7:0]              g_data,
	output logic [7:0]              b_data,
	output logic                    hs,
	output logic                    vs,
	output logic                    blank_n
);

	game_pkg::color_idx_t idx;
	game_pkg::rgb_t       pixel_rgb;

	// Strict bounds, the left column and top row are not covered
	function automatic logic hit(
		input vga_timing_pkg::coord_t px,
		input vga_timing_pkg::coord_t py,
		input int                     left,
		input int                     top,
		input int                     w,
		input int                     h
	);
		vga_timing_pkg::coord_t dx;
		vga_timing_pkg::coord_t dy;
		dx = px - vga_timing_pkg::coord_t'(left);
		dy = py - vga_timing_pkg::coord_t'(top);
		return (dx != '0) && (int'(dx) < w) && (dy != '0) && (int'(dy) < h);
	endfunction

	// ==========================================================
	// Layers, lowest first, later hits win
	// ==========================================================

	always_comb
	begin
		idx = game_pkg::IDX_BG;

		// Paddles and ball
		if (hit(raster.x, raster.y, int'(frame_state.pl_x), int'(frame_state.pl_y),
			game_pkg::PADDLE_W, game_pkg::PADDLE_H))
			idx = game_pkg::IDX_WHITE;
		if (hit(raster.x, raster.y, int'(frame_state.pr_x), int'(frame_state.pr_y),
			game_pkg::PADDLE_W, game_pkg::PADDLE_H))
			idx = game_pkg::IDX_WHITE;
		if (hit(raster.x, raster.y, int'(frame_state.ball_x), int'(frame_state.ball_y),
			game_pkg::BALL_W, game_pkg::BALL_H))
			idx = game_pkg::IDX_WHITE;

		// Strings sit above the paddles
		for (int k = 0; k < 3; k++)
		begin
			if (hit(raster.x, raster.y, game_pkg::STRING_X, game_pkg::STRING_Y[k],
				game_pkg::STRING_W, game_pkg::STRING_H))
				idx = game_pkg::IDX_BLACK;
		end

		// Mode box, or the game-over box once the game ends
		if (frame_state.mode == game_pkg::MODE_OVER)
		begin
			if (hit(raster.x, raster.y, game_pkg::OVER_BOX_X, game_pkg::OVER_BOX_Y,
				game_pkg::BOX_W, game_pkg::BOX_H))
				idx = game_pkg::IDX_GREEN;
		end
		else if (hit(raster.x, raster.y, game_pkg::MODE_BOX_X, game_pkg::MODE_BOX_Y,
			game_pkg::BOX_W, game_pkg::BOX_H))
		begin
			case (frame_state.mode)
				game_pkg::MODE_MENU:   idx = game_pkg::IDX_YELLOW;
				game_pkg::MODE_SINGLE: idx = game_pkg::IDX_RED;
				default:               idx = game_pkg::IDX_BLACK;
			endcase
		end

		// Lives, square k lit while the count exceeds k
		for (int k = 0; k < 3; k++)
		begin
			if (frame_state.p1_lives > game_pkg::lives_t'(k) &&
				hit(raster.x, raster.y, game_pkg::LIFE_P1_X[k], game_pkg::LIFE_Y,
				game_pkg::LIFE_SIZE, game_pkg::LIFE_SIZE))
				idx = game_pkg::IDX_RED;
			if (frame_state.p2_lives > game_pkg::lives_t'(k) &&
				hit(raster.x, raster.y, game_pkg::LIFE_P2_X[k], game_pkg::LIFE_Y,
				game_pkg::LIFE_SIZE, game_pkg::LIFE_SIZE))
				idx = game_pkg::IDX_RED;
		end

		// Black outside the visible area
		pixel_rgb = raster.active ? game_pkg::PALETTE[idx] : '0;
	end

	// ==========================================================
	// Output stage, color and syncs leave together
	// ==========================================================

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			r_data  <= '0;
			g_data  <= '0;
			b_data  <= '0;
			hs      <= 1'b1;
			vs      <= 1'b1;
			blank_n <= 1'b0;
		end
		else
		begin
			r_data  <= pixel_rgb[23:16];
			g_data  <= pixel_rgb[15:8];
			b_data  <= pixel_rgb[7:0];
			hs      <= raster.hsync;
			vs      <= raster.vsync;
			blank_n <= raster.active;
		end
	end

endmodule

// File: rtl/vga_game_top.sv
`timescale 1ns/1ps

module vga_game_top #(
	parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
	parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
	parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
	parameter int H_BACK   = vga_timing_pkg::H_BACK,
	parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
	parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
	parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
	parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
	input  logic        iVGA_CLK,
	input  logic        iRST_n,
	// APB3 host port
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	// Video out
	output logic [7:0]  r_data,
	output logic [7:0]  g_data,
	output logic [7:0]  b_data,
	output logic        hs,
	output logic        vs,
	output logic        blank_n
);

	vga_timing_pkg::raster_t raster;
	game_pkg::game_state_t   live_state;
	game_pkg::game_state_t   frame_state;

	// ==========================================================
	// Timing, host registers, snapshot and pixel pipeline
	// ==========================================================

	raster_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) u_raster_timing (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.raster   (raster)
	);

	apb_game_regs u_apb_game_regs (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.live_state (live_state)
	);

	frame_shadow u_frame_shadow (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.raster      (raster),
		.live_state  (live_state),
		.frame_state (frame_state)
	);

	pixel_compositor u_pixel_compositor (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.raster      (raster),
		.frame_state (frame_state),
		.r_data      (r_data),
		.g_data      (g_data),
		.b_data      (b_data),
		.hs          (hs),
		.vs          (vs),
		.blank_n     (blank_n)
	);

endmodule

// File: verif/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

	// ==========================================================
	// APB3 host side
	// ==========================================================

	// Setup phase, then access phase until pready, inputs move 1 ns after the edge
	task automatic apb_transfer(
		input  logic        write,
		input  logic [7:0]  addr,
		input  logic [31:0] wdata,
		output logic [31:0] rdata,
		output logic        err
	);
		int   waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		rdata  = '0;
		err    = 1'b0;
		@(posedge iVGA_CLK);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge iVGA_CLK);
		#1;
		penable = 1'b1;
		while (!done)
		begin
			// Response sampled mid-cycle, the next edge ends the transfer
			@(negedge iVGA_CLK);
			if (pready)
			begin
				rdata = prdata;
				err   = pslverr;
				done  = 1'b1;
			end
			else if (waited >= APB_TIMEOUT)
			begin
				$display("Timeout: pready stayed low for %0d cycles at address 0x%02h",
					waited, addr);
				timeouts++;
				done = 1'b1;
			end
			waited++;
			@(posedge iVGA_CLK);
		end
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		apb_transfer(1'b1, addr, data, rdata, err);
		test_errors += value_mismatch($sformatf("pslverr @0x%02h", addr), 32'(exp_err),
			32'(err));
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		input logic exp_err);
		logic err;
		apb_transfer(1'b0, addr, 32'h0, data, err);
		test_errors += value_mismatch($sformatf("pslverr @0x%02h", addr), 32'(exp_err),
			32'(err));
	endtask

`endif

// File: verif/tb_vga_game.sv
`timescale 1ns/1ps

module tb_vga_game;

	localparam int FRAME_CYCLES = 800 * 525;
	localparam int APB_TIMEOUT  = 16;
	localparam int WAIT_TIMEOUT = 2 * FRAME_CYCLES;

	// Expected colors as 0x00RRGGBB
	localparam logic [31:0] C_BG     = 32'h00102040;
	localparam logic [31:0] C_WHITE  = 32'h00FFFFFF;
	localparam logic [31:0] C_RED    = 32'h00FF0000;
	localparam logic [31:0] C_GREEN  = 32'h0000FF00;
	localparam logic [31:0] C_YELLOW = 32'h00FFFF00;
	localparam logic [31:0] C_BLACK  = 32'h00000000;

	localparam logic [7:0] REG_ADDR [5] = '{game_pkg::REG_BALL, game_pkg::REG_PADDLE_L,
		game_pkg::REG_PADDLE_R, game_pkg::REG_MODE, game_pkg::REG_LIVES};
	// Defined fields of each register
	localparam logic [31:0] REG_MASK [5] = '{32'h03FF03FF, 32'h03FF03FF, 32'h03FF03FF,
		32'h00000003, 32'h00000077};
	localparam logic [7:0] BAD_ADDR [4] = '{8'h14, 8'h02, 8'h40, 8'hFC};

	logic        iVGA_CLK;
	logic        iRST_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [7:0]  r_data;
	logic [7:0]  g_data;
	logic [7:0]  b_data;
	logic        hs;
	logic        vs;
	logic        blank_n;

	int seed = 32'h7498;

	// Failure counters, one per checking process
	int test_errors    = 0;
	int monitor_errors = 0;
	int blank_errors   = 0;
	int ready_errors   = 0;
	int timeouts       = 0;

	// Raster monitor state
	logic        prev_hs;
	logic        prev_vs;
	logic        prev_blank;
	bit          hs_seen;
	bit          vs_seen;
	bit          trk_valid;
	int          line_len;
	int          hs_low_len;
	int          frame_lines;
	int          vs_low_lines;
	int          active_lines;
	int          pix_x;
	int          line_y;
	int          frame_cnt;
	int          probe_x = -1;
	int          probe_y = -1;
	int          probe_hits;
	int          probe_frame;
	logic [31:0] probe_rgb;

	vga_game_top dut (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.r_data   (r_data),
		.g_data   (g_data),
		.b_data   (b_data),
		.hs       (hs),
		.vs       (vs),
		.blank_n  (blank_n)
	);

	initial
	begin
		iVGA_CLK = 1'b0;
		forever #5 iVGA_CLK = ~iVGA_CLK;
	end

	function automatic int value_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		int bad;
		bad = 0;
		assert (got === exp)
		else
		begin
			$display("** Error: %s expected 0x%0h got 0x%0h", name, exp, got);
			bad = 1;
		end
		return bad;
	endfunction

	function automatic logic [31:0] pack_position(input int x, input int y);
		return {6'b0, x[9:0], 6'b0, y[9:0]};
	endfunction

	`include "tb_apb_tasks.svh"

	// ==========================================================
	// Protocol and blanking properties
	// ==========================================================

	blank_black: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		!blank_n |-> ({r_data, g_data, b_data} == 24'h0))
	else
	begin
		$display("** Error: {r_data,g_data,b_data} expected 0x0 got 0x%06h in blanking",
			$sampled({r_data, g_data, b_data}));
		blank_errors++;
	end

	ready_in_access: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(psel && penable) |-> pready)
	else
	begin
		$display("** Error: pready expected 0x1 got 0x0 in an access phase");
		ready_errors++;
	end

	// ==========================================================
	// Raster monitor, sampled mid-cycle
	// ==========================================================

	always @(negedge iVGA_CLK)
	begin
		if (!iRST_n)
		begin
			prev_hs      = 1'b1;
			prev_vs      = 1'b1;
			prev_blank   = 1'b0;
			hs_seen      = 1'b0;
			vs_seen      = 1'b0;
			trk_valid    = 1'b0;
			line_len     = 0;
			hs_low_len   = 0;
			frame_lines  = 0;
			vs_low_lines = 0;
			active_lines = 0;
			pix_x        = 0;
			line_y       = 0;
			frame_cnt    = 0;
			probe_hits   = 0;
		end
		else
		begin
			line_len++;
			if (!hs)
				hs_low_len++;
			// Line period measured between falling edges of hs
			if (prev_hs && !hs)
			begin
				if (hs_seen)
					monitor_errors += value_mismatch("hs period", 32'd800, line_len);
				line_len = 0;
				hs_seen  = 1'b1;
				frame_lines++;
				if (!vs)
					vs_low_lines++;
			end
			if (!prev_hs && hs)
			begin
				monitor_errors += value_mismatch("hs low cycles", 32'd96, hs_low_len);
				hs_low_len = 0;
			end
			// Pixel under the beam
			if (blank_n)
			begin
				if (trk_valid && pix_x == probe_x && line_y == probe_y)
				begin
					probe_rgb   = {8'h00, r_data, g_data, b_data};
					probe_frame = frame_cnt;
					probe_hits++;
				end
				pix_x++;
			end
			if (prev_blank && !blank_n)
			begin
				monitor_errors += value_mismatch("blank_n high cycles", 32'd640, pix_x);
				pix_x = 0;
				line_y++;
				active_lines++;
			end
			if (prev_vs && !vs)
			begin
				if (vs_seen)
				begin
					monitor_errors += value_mismatch("vs period lines", 32'd525, frame_lines);
					monitor_errors += value_mismatch("blank_n active lines", 32'd480,
						active_lines);
				end
				frame_lines  = 0;
				active_lines = 0;
				vs_seen      = 1'b1;
			end
			// Rising vs marks the next frame, active lines count from here
			if (!prev_vs && vs)
			begin
				monitor_errors += value_mismatch("vs low lines", 32'd2, vs_low_lines);
				vs_low_lines = 0;
				line_y       = 0;
				trk_valid    = 1'b1;
				frame_cnt++;
			end
			prev_hs    = hs;
			prev_vs    = vs;
			prev_blank = blank_n;
		end
	end

	// ==========================================================
	// Waits, each bounded
	// ==========================================================

	task automatic wait_next_frame();
		int start;
		int waited;
		start  = frame_cnt;
		waited = 0;
		while (frame_cnt == start && waited < WAIT_TIMEOUT)
		begin
			@(posedge iVGA_CLK);
			waited++;
		end
		if (frame_cnt == start)
		begin
			$display("Timeout: no rising edge on vs within %0d cycles", WAIT_TIMEOUT);
			timeouts++;
		end
	endtask

	task automatic wait_for_line(input int y);
		int waited;
		waited = 0;
		while (!(trk_valid && line_y == y) && waited < WAIT_TIMEOUT)
		begin
			@(posedge iVGA_CLK);
			waited++;
		end
		if (!(trk_valid && line_y == y))
		begin
			$display("Timeout: active line %0d never reached", y);
			timeouts++;
		end
	endtask

	// Next scan of pixel (x,y), with the frame it belongs to
	task automatic probe_pixel(input int x, input int y, output logic [31:0] rgb,
		output int frame);
		int hits;
		int waited;
		hits    = probe_hits;
		probe_x = x;
		probe_y = y;
		waited  = 0;
		while (probe_hits == hits && waited < WAIT_TIMEOUT)
		begin
			@(posedge iVGA_CLK);
			waited++;
		end
		if (probe_hits == hits)
		begin
			$display("Timeout: pixel (%0d,%0d) was never scanned", x, y);
			timeouts++;
		end
		rgb   = probe_rgb;
		frame = probe_frame;
	endtask

	task automatic check_pixel(input int x, input int y, input logic [31:0] exp);
		logic [31:0] rgb;
		int          frame;
		probe_pixel(x, y, rgb, frame);
		test_errors += value_mismatch($sformatf("{r_data,g_data,b_data} at (%0d,%0d)", x, y),
			exp, rgb);
	endtask

	// ==========================================================
	// Test phases
	// ==========================================================

	task automatic check_register_access();
		logic [31:0] model [5];
		logic [31:0] data;
		logic [31:0] rdata;
		for (int i = 0; i < 5; i++)
		begin
			apb_read(REG_ADDR[i], rdata, 1'b0);
			test_errors += value_mismatch("prdata after reset", 32'h0, rdata);
			model[i] = 32'h0;
		end
		for (int round = 0; round < 3; round++)
		begin
			for (int i = 0; i < 5; i++)
			begin
				data = $random(seed);
				apb_write(REG_ADDR[i], data, 1'b0);
				model[i] = data & REG_MASK[i];
				apb_read(REG_ADDR[i], rdata, 1'b0);
				test_errors += value_mismatch($sformatf("prdata @0x%02h", REG_ADDR[i]),
					model[i], rdata);
			end
		end
		// Unmapped space errors out and leaves the map alone
		for (int j = 0; j < 4; j++)
		begin
			apb_write(BAD_ADDR[j], $random(seed), 1'b1);
			apb_read(BAD_ADDR[j], rdata, 1'b1);
			test_errors += value_mismatch($sformatf("prdata @0x%02h", BAD_ADDR[j]), 32'h0,
				rdata);
		end
		for (int i = 0; i < 5; i++)
		begin
			apb_read(REG_ADDR[i], rdata, 1'b0);
			test_errors += value_mismatch($sformatf("prdata @0x%02h", REG_ADDR[i]),
				model[i], rdata);
		end
	endtask

	task automatic check_frame_consistency();
		logic [31:0] rgb;
		int          write_frame;
		int          frame;
		wait_for_line(100);
		write_frame = frame_cnt;
		apb_write(game_pkg::REG_BALL, pack_position(400, 300), 1'b0);
		// Rest of this frame still uses the old ball
		probe_pixel(410, 310, rgb, frame);
		test_errors += value_mismatch("{r_data,g_data,b_data} at (410,310)", C_BG, rgb);
		assert (frame == write_frame)
		else
		begin
			$display("Ball center was not scanned in the frame of the write");
			test_errors++;
		end
		probe_pixel(410, 310, rgb, frame);
		test_errors += value_mismatch("{r_data,g_data,b_data} at (410,310)", C_WHITE, rgb);
		assert (frame == write_frame + 1)
		else
		begin
			$display("Ball center was not scanned in the frame after the write");
			test_errors++;
		end
	endtask

	task automatic check_layering();
		check_pixel(110, 63, C_BLACK);
		check_pixel(110, 100, C_WHITE);
		check_pixel(570, 350, C_WHITE);
		// p1 has 2 lives, p2 has 1
		check_pixel(25, 465, C_RED);
		check_pixel(45, 465, C_RED);
		check_pixel(65, 465, C_BG);
		check_pixel(605, 465, C_RED);
		check_pixel(585, 465, C_BG);
		check_pixel(170, 170, C_YELLOW);
		apb_write(game_pkg::REG_MODE, 32'h1, 1'b0);
		wait_next_frame();
		check_pixel(170, 170, C_RED);
		apb_write(game_pkg::REG_MODE, 32'h2, 1'b0);
		wait_next_frame();
		check_pixel(170, 170, C_BLACK);
		apb_write(game_pkg::REG_MODE, 32'h3, 1'b0);
		wait_next_frame();
		check_pixel(270, 170, C_GREEN);
		check_pixel(170, 170, C_BG);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial
	begin
		iRST_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h00;
		pwdata  = 32'h0;
		repeat (2) @(posedge iVGA_CLK);
		@(negedge iVGA_CLK);
		test_errors += value_mismatch("hs", 32'd1, 32'(hs));
		test_errors += value_mismatch("vs", 32'd1, 32'(vs));
		test_errors += value_mismatch("blank_n", 32'd0, 32'(blank_n));
		test_errors += value_mismatch("{r_data,g_data,b_data}", 32'h0,
			{8'h00, r_data, g_data, b_data});
		test_errors += value_mismatch("pslverr", 32'd0, 32'(pslverr));
		repeat (6) @(posedge iVGA_CLK);
		#1;
		iRST_n = 1'b1;

		check_register_access();

		// Scene clear of the ball target at (400,300)
		apb_write(game_pkg::REG_PADDLE_L, pack_position(100, 20), 1'b0);
		apb_write(game_pkg::REG_PADDLE_R, pack_position(560, 300), 1'b0);
		apb_write(game_pkg::REG_BALL, pack_position(500, 400), 1'b0);
		apb_write(game_pkg::REG_LIVES, 32'h21, 1'b0);
		apb_write(game_pkg::REG_MODE, 32'h0, 1'b0);
		wait_next_frame();

		check_frame_consistency();
		check_layering();

		$display("Checks done: %0d test, %0d monitor, %0d blanking, %0d pready errors, %0d timeouts",
			test_errors, monitor_errors, blank_errors, ready_errors, timeouts);
		if (test_errors + monitor_errors + blank_errors + ready_errors + timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+verif
rtl/vga_timing_pkg.sv
rtl/game_pkg.sv
rtl/raster_timing.sv
rtl/apb_game_regs.sv
rtl/frame_shadow.sv
rtl/pixel_compositor.sv
rtl/vga_game_top.sv
verif/tb_vga_game.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run, the exit status follows the testbench result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_vga_game \
	&& ./obj_dir/Vtb_vga_game | tee /dev/stderr | grep -q "^Simulation PASSED$" \
	&& exit 0 \
	|| exit 1
